// ==== common/tsc_pkg.sv ====
package tsc_pkg;

	localparam int word_width = 16;
	localparam int reg_count = 4;

	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

	// Opcode 15 holds all R-type instructions, told apart by func
	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		func_t func;
	} r_fields_t;

	// Jump target is {rs, rt, imm}
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [7:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t rtype;
		i_fields_t itype;
	} instr_u;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_pass_b,
		alu_bne,
		alu_beq,
		alu_bgz,
		alu_blz
	} alu_op_t;

	typedef enum logic [1:0] {
		src_a_pc,
		src_a_reg
	} src_a_t;

	typedef enum logic [1:0] {
		src_b_reg,
		src_b_one,
		src_b_imm,
		src_b_upper
	} src_b_t;

	typedef enum logic [1:0] {
		wdest_rd,
		wdest_rt,
		wdest_link
	} wdest_t;

	typedef struct packed {
		logic pc_write;
		logic pc_from_alu_out;
		logic pc_from_target;
		logic pc_from_reg;
		logic i_or_d;
		logic mem_read;
		logic mem_write;
		logic ir_write;
		logic mdr_write;
		logic reg_write;
		wdest_t wdest;
		logic mem_to_reg;
		logic pc_to_reg;
		src_a_t src_a;
		src_b_t src_b;
		alu_op_t alu_op;
		logic aout_write;
		logic count_inst;
		logic wwd;
	} ctrl_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic [tsc_pkg::word_width-1:0] a,
	input logic [tsc_pkg::word_width-1:0] b,
	input tsc_pkg::alu_op_t op,
	output logic [tsc_pkg::word_width-1:0] result,
	output logic bcond
);

	localparam int w = tsc_pkg::word_width;

	logic [w-1:0] diff;

	assign diff = a - b;

	always_comb begin
		result = a + b;
		bcond = 1'b0;
		case (op)
			tsc_pkg::alu_sub: result = diff;
			tsc_pkg::alu_and: result = a & b;
			tsc_pkg::alu_or: result = a | b;
			tsc_pkg::alu_not: result = ~a;
			tsc_pkg::alu_tcp: result = ~a + 1'b1;
			tsc_pkg::alu_shl: result = {a[w-2:0], 1'b0};
			// Arithmetic shift keeps the sign
			tsc_pkg::alu_shr: result = {a[w-1], a[w-1:1]};
			tsc_pkg::alu_pass_b: result = b;
			// Compares leave the difference on result
			tsc_pkg::alu_bne: begin
				result = diff;
				bcond = |diff;
			end
			tsc_pkg::alu_beq: begin
				result = diff;
				bcond = ~|diff;
			end
			tsc_pkg::alu_bgz: begin
				result = diff;
				bcond = !a[w-1] && (|a);
			end
			tsc_pkg::alu_blz: begin
				result = diff;
				bcond = a[w-1];
			end
			default: result = a + b;
		endcase
	end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic reset_n,
	input tsc_pkg::reg_idx_t read_idx_1,
	input tsc_pkg::reg_idx_t read_idx_2,
	input tsc_pkg::reg_idx_t write_idx,
	input logic [tsc_pkg::word_width-1:0] write_data,
	input logic write_en,
	output logic [tsc_pkg::word_width-1:0] read_out_1,
	output logic [tsc_pkg::word_width-1:0] read_out_2
);

	logic [tsc_pkg::word_width-1:0] regs [tsc_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < tsc_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	// Asynchronous reads
	assign read_out_1 = regs[read_idx_1];
	assign read_out_2 = regs[read_idx_2];

endmodule

// ==== hw/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset_n,
	input tsc_pkg::ctrl_t ctrl,
	input logic [tsc_pkg::word_width-1:0] read_data,
	output tsc_pkg::instr_u instr,
	output logic bcond,
	output logic read_m,
	output logic write_m,
	output logic [tsc_pkg::word_width-1:0] address,
	output logic [tsc_pkg::word_width-1:0] write_data,
	output logic [tsc_pkg::word_width-1:0] num_inst,
	output logic [tsc_pkg::word_width-1:0] output_port
);

	localparam int w = tsc_pkg::word_width;

	tsc_pkg::instr_u ir;
	tsc_pkg::reg_idx_t write_idx;
	logic [w-1:0] pc;
	logic [w-1:0] mdr;
	logic [w-1:0] reg_a;
	logic [w-1:0] reg_b;
	logic [w-1:0] alu_out;
	logic [w-1:0] rf_out_1;
	logic [w-1:0] rf_out_2;
	logic [w-1:0] rf_write_data;
	logic [w-1:0] imm_ext;
	logic [w-1:0] upper_imm;
	logic [w-1:0] jump_target;
	logic [w-1:0] alu_a;
	logic [w-1:0] alu_b;
	logic [w-1:0] alu_result;
	logic [w-1:0] pc_next;

	assign instr = ir;
	assign read_m = ctrl.mem_read;
	assign write_m = ctrl.mem_write;
	assign address = ctrl.i_or_d ? alu_out : pc;
	assign write_data = reg_b;

	// ORI zero-extends, every other immediate is signed
	assign imm_ext = (ir.itype.opcode == tsc_pkg::op_ori) ? {{(w-8){1'b0}}, ir.itype.imm}
		: {{(w-8){ir.itype.imm[7]}}, ir.itype.imm};
	assign upper_imm = {ir.itype.imm, {(w-8){1'b0}}};
	assign jump_target = {pc[w-1:12], ir.itype.rs, ir.itype.rt, ir.itype.imm};

	assign alu_a = (ctrl.src_a == tsc_pkg::src_a_reg) ? reg_a : pc;

	always_comb begin
		case (ctrl.src_b)
			tsc_pkg::src_b_one: alu_b = {{(w-1){1'b0}}, 1'b1};
			tsc_pkg::src_b_imm: alu_b = imm_ext;
			tsc_pkg::src_b_upper: alu_b = upper_imm;
			default: alu_b = reg_b;
		endcase
	end

	always_comb begin
		case (ctrl.wdest)
			tsc_pkg::wdest_rd: write_idx = ir.rtype.rd;
			tsc_pkg::wdest_link: write_idx = 2'd2;
			default: write_idx = ir.rtype.rt;
		endcase
	end

	// PC already holds PC+1 once the instruction is fetched
	assign rf_write_data = ctrl.pc_to_reg ? pc : (ctrl.mem_to_reg ? mdr : alu_out);

	always_comb begin
		if (ctrl.pc_from_alu_out) begin
			pc_next = alu_out;
		end else if (ctrl.pc_from_target) begin
			pc_next = jump_target;
		end else if (ctrl.pc_from_reg) begin
			pc_next = rf_out_1;
		end else begin
			pc_next = alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			ir <= '0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (ctrl.pc_write) begin
				pc <= pc_next;
			end
			if (ctrl.ir_write) begin
				ir <= read_data;
			end
			if (ctrl.count_inst) begin
				num_inst <= num_inst + 1'b1;
			end
			if (ctrl.wwd) begin
				output_port <= rf_out_1;
			end
		end
	end

	always_ff @(posedge clk) begin
		reg_a <= rf_out_1;
		reg_b <= rf_out_2;
		if (ctrl.aout_write) begin
			alu_out <= alu_result;
		end
		if (ctrl.mdr_write) begin
			mdr <= read_data;
		end
	end

	register_file u_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.read_idx_1(ir.rtype.rs),
		.read_idx_2(ir.rtype.rt),
		.write_idx(write_idx),
		.write_data(rf_write_data),
		.write_en(ctrl.reg_write),
		.read_out_1(rf_out_1),
		.read_out_2(rf_out_2)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.bcond(bcond)
	);

endmodule

// ==== hw/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm (
	input logic clk,
	input logic reset_n,
	input tsc_pkg::instr_u instr,
	input logic bcond,
	output tsc_pkg::ctrl_t ctrl,
	output logic is_halted
);

	typedef enum logic [3:0] {
		s_init,
		s_if1,
		s_if2,
		s_id,
		s_ex,
		s_mem1,
		s_mem2,
		s_wb,
		s_halt
	} state_t;

	state_t state;
	state_t state_next;
	tsc_pkg::opcode_t opcode;
	tsc_pkg::func_t func;
	logic is_rtype;
	logic is_alu_r;
	logic is_alu_i;
	logic is_branch;
	logic is_mem;

	function automatic tsc_pkg::alu_op_t r_alu_op(input tsc_pkg::func_t f);
		case (f)
			tsc_pkg::fn_sub: return tsc_pkg::alu_sub;
			tsc_pkg::fn_and: return tsc_pkg::alu_and;
			tsc_pkg::fn_orr: return tsc_pkg::alu_or;
			tsc_pkg::fn_not: return tsc_pkg::alu_not;
			tsc_pkg::fn_tcp: return tsc_pkg::alu_tcp;
			tsc_pkg::fn_shl: return tsc_pkg::alu_shl;
			tsc_pkg::fn_shr: return tsc_pkg::alu_shr;
			default: return tsc_pkg::alu_add;
		endcase
	endfunction

	function automatic tsc_pkg::alu_op_t branch_op(input tsc_pkg::opcode_t op);
		case (op)
			tsc_pkg::op_beq: return tsc_pkg::alu_beq;
			tsc_pkg::op_bgz: return tsc_pkg::alu_bgz;
			tsc_pkg::op_blz: return tsc_pkg::alu_blz;
			default: return tsc_pkg::alu_bne;
		endcase
	endfunction

	// Opcode from the I view, function from the R view
	assign opcode = instr.itype.opcode;
	assign func = instr.rtype.func;
	assign is_rtype = (opcode == tsc_pkg::op_rtype);
	assign is_alu_r = is_rtype && (func inside {[tsc_pkg::fn_add:tsc_pkg::fn_shr]});
	assign is_alu_i = opcode inside {tsc_pkg::op_adi, tsc_pkg::op_ori, tsc_pkg::op_lhi};
	assign is_branch = opcode inside {[tsc_pkg::op_bne:tsc_pkg::op_blz]};
	assign is_mem = opcode inside {tsc_pkg::op_lwd, tsc_pkg::op_swd};
	assign is_halted = (state == s_halt);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= s_init;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		ctrl = '0;
		state_next = state;
		case (state)
			s_init: state_next = s_if1;
			s_if1: begin
				ctrl.mem_read = 1'b1;
				state_next = s_if2;
			end
			// PC moves to PC+1 here, jumps and branches overwrite it later
			s_if2: begin
				ctrl.ir_write = 1'b1;
				ctrl.src_a = tsc_pkg::src_a_pc;
				ctrl.src_b = tsc_pkg::src_b_one;
				ctrl.alu_op = tsc_pkg::alu_add;
				ctrl.aout_write = 1'b1;
				ctrl.pc_write = 1'b1;
				state_next = s_id;
			end
			s_id: begin
				// Branch target into ALU out
				ctrl.src_a = tsc_pkg::src_a_pc;
				ctrl.src_b = tsc_pkg::src_b_imm;
				ctrl.alu_op = tsc_pkg::alu_add;
				ctrl.aout_write = 1'b1;
				state_next = s_if1;
				if (is_rtype && func == tsc_pkg::fn_hlt) begin
					ctrl.count_inst = 1'b1;
					state_next = s_halt;
				end else if (opcode inside {tsc_pkg::op_jmp, tsc_pkg::op_jal}) begin
					ctrl.pc_write = 1'b1;
					ctrl.pc_from_target = 1'b1;
					ctrl.count_inst = 1'b1;
					ctrl.reg_write = (opcode == tsc_pkg::op_jal);
				end else if (is_rtype && func inside {tsc_pkg::fn_jpr, tsc_pkg::fn_jrl}) begin
					ctrl.pc_write = 1'b1;
					ctrl.pc_from_reg = 1'b1;
					ctrl.count_inst = 1'b1;
					ctrl.reg_write = (func == tsc_pkg::fn_jrl);
				end else if (is_rtype && func == tsc_pkg::fn_wwd) begin
					ctrl.wwd = 1'b1;
					ctrl.count_inst = 1'b1;
				end else if (is_branch || is_mem || is_alu_r || is_alu_i) begin
					state_next = s_ex;
				end else begin
					// Unknown encodings retire as no-ops
					ctrl.count_inst = 1'b1;
				end
				// Links always go to register 2 with PC+1
				ctrl.wdest = tsc_pkg::wdest_link;
				ctrl.pc_to_reg = 1'b1;
			end
			s_ex: begin
				ctrl.src_a = tsc_pkg::src_a_reg;
				ctrl.aout_write = 1'b1;
				state_next = s_wb;
				if (is_branch) begin
					ctrl.src_b = tsc_pkg::src_b_reg;
					ctrl.alu_op = branch_op(opcode);
					ctrl.aout_write = 1'b0;
					ctrl.pc_write = bcond;
					ctrl.pc_from_alu_out = 1'b1;
					ctrl.count_inst = 1'b1;
					state_next = s_if1;
				end else if (is_mem) begin
					ctrl.src_b = tsc_pkg::src_b_imm;
					ctrl.alu_op = tsc_pkg::alu_add;
					state_next = s_mem1;
				end else if (opcode == tsc_pkg::op_lhi) begin
					ctrl.src_b = tsc_pkg::src_b_upper;
					ctrl.alu_op = tsc_pkg::alu_pass_b;
				end else if (is_alu_i) begin
					ctrl.src_b = tsc_pkg::src_b_imm;
					ctrl.alu_op = (opcode == tsc_pkg::op_ori) ? tsc_pkg::alu_or
						: tsc_pkg::alu_add;
				end else begin
					ctrl.src_b = tsc_pkg::src_b_reg;
					ctrl.alu_op = r_alu_op(func);
				end
			end
			s_mem1: begin
				ctrl.i_or_d = 1'b1;
				if (opcode == tsc_pkg::op_lwd) begin
					ctrl.mem_read = 1'b1;
					state_next = s_mem2;
				end else begin
					ctrl.mem_write = 1'b1;
					ctrl.count_inst = 1'b1;
					state_next = s_if1;
				end
			end
			s_mem2: begin
				ctrl.mdr_write = 1'b1;
				state_next = s_wb;
			end
			s_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.count_inst = 1'b1;
				ctrl.mem_to_reg = (opcode == tsc_pkg::op_lwd);
				ctrl.wdest = is_rtype ? tsc_pkg::wdest_rd : tsc_pkg::wdest_rt;
				state_next = s_if1;
			end
			default: state_next = s_halt;
		endcase
	end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic reset_n,
	output logic read_m,
	output logic write_m,
	output logic [tsc_pkg::word_width-1:0] address,
	output logic [tsc_pkg::word_width-1:0] write_data,
	input logic [tsc_pkg::word_width-1:0] read_data,
	output logic [tsc_pkg::word_width-1:0] num_inst,
	output logic [tsc_pkg::word_width-1:0] output_port,
	output logic is_halted
);

	tsc_pkg::ctrl_t ctrl;
	tsc_pkg::instr_u instr;
	logic bcond;

	control_fsm u_control_fsm (
		.clk(clk),
		.reset_n(reset_n),
		.instr(instr),
		.bcond(bcond),
		.ctrl(ctrl),
		.is_halted(is_halted)
	);

	datapath u_datapath (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl),
		.read_data(read_data),
		.instr(instr),
		.bcond(bcond),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.write_data(write_data),
		.num_inst(num_inst),
		.output_port(output_port)
	);

endmodule

// ==== tests/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory (
	input logic clk,
	input logic read_m,
	input logic write_m,
	input logic [tsc_pkg::word_width-1:0] address,
	input logic [tsc_pkg::word_width-1:0] write_data,
	output logic [tsc_pkg::word_width-1:0] read_data
);

	localparam int depth = 1 << tsc_pkg::word_width;

	typedef logic [tsc_pkg::word_width-1:0] word_t;

	word_t mem [depth];
	word_t log_addr [$];
	word_t log_data [$];

	initial begin
		read_data = '0;
	end

	// Read data shows up one cycle after the request
	always @(posedge clk) begin
		if (read_m) begin
			read_data <= #2 mem[address];
		end
		if (write_m) begin
			mem[address] <= write_data;
			log_addr.push_back(address);
			log_data.push_back(write_data);
		end
	end

	task automatic load_word(input word_t addr, input word_t data);
		mem[addr] = data;
	endtask

	task automatic clear_log();
		log_addr.delete();
		log_data.delete();
	endtask

endmodule

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

	localparam int clk_period = 40;
	localparam int num_tests = 4;
	localparam int max_steps = 200;
	localparam int mem_words = 1 << tsc_pkg::word_width;

	typedef logic [tsc_pkg::word_width-1:0] word_t;

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	logic read_m;
	logic write_m;
	logic is_halted;
	word_t address;
	word_t write_data;
	word_t read_data;
	word_t num_inst;
	word_t output_port;

	word_t image [mem_words];
	word_t model_mem [mem_words];
	word_t exp_port [$];
	word_t exp_wr_addr [$];
	word_t exp_wr_data [$];
	int exp_count;
	int cursor;
	int errors = 0;
	int failed_tests = 0;
	int seed_draw;
	logic checking = 1'b0;
	logic quiet = 1'b0;
	logic halt_seen = 1'b0;

	cpu DUT (
		.clk(clk),
		.reset_n(reset_n),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.write_data(write_data),
		.read_data(read_data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	tb_memory mem_model (
		.clk(clk),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.write_data(write_data),
		.read_data(read_data)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic note_failure(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t expected);
		assert (got === expected) else begin
			errors++;
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
		end
	endtask

	// High while the last edge saw reset
	always @(posedge clk) begin
		quiet <= !reset_n;
	end

	always @(negedge clk) begin
		if (quiet) begin
			halt_seen = 1'b0;
			assert (!read_m && !write_m) else note_failure("memory request during reset");
			assert (!is_halted) else note_failure("is_halted high during reset");
			compare_word("num_inst", num_inst, '0);
			compare_word("output_port", output_port, '0);
		end else if (reset_n) begin
			assert (!(read_m && write_m)) else note_failure("read_m and write_m high together");
			if (checking) begin
				if (num_inst < exp_port.size()) begin
					compare_word("output_port", output_port, exp_port[num_inst]);
				end else begin
					note_failure("num_inst ran past the expected instruction count");
					checking = 1'b0;
				end
			end
			if (halt_seen || is_halted) begin
				assert (is_halted) else note_failure("is_halted dropped before reset");
				assert (!read_m && !write_m) else note_failure("memory request after halt");
				halt_seen = 1'b1;
			end
		end
	end

	function automatic word_t r_instr(input logic [5:0] fn, input int rs, input int rt,
		input int rd);
		return {tsc_pkg::op_rtype, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	function automatic word_t i_instr(input logic [3:0] op, input int rs, input int rt,
		input int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic word_t j_instr(input logic [3:0] op, input int target);
		return {op, target[11:0]};
	endfunction

	// Unused words depend on every address bit
	function automatic word_t fill_word(input int a);
		word_t addr;
		addr = word_t'(a);
		return {addr[7:0], addr[15:8]} ^ 16'hc3e1;
	endfunction

	task automatic start_program();
		int i;
		for (i = 0; i < mem_words; i++) begin
			image[i] = fill_word(i);
		end
		cursor = 0;
	endtask

	task automatic emit(input word_t w);
		image[cursor] = w;
		cursor++;
	endtask

	task automatic load_const(input int r, input word_t value);
		emit(i_instr(tsc_pkg::op_lhi, 0, r, value[15:8]));
		emit(i_instr(tsc_pkg::op_ori, r, r, value[7:0]));
	endtask

	task automatic emit_wwd(input int r);
		emit(r_instr(tsc_pkg::fn_wwd, r, 0, 0));
	endtask

	task automatic emit_halt();
		emit(r_instr(tsc_pkg::fn_hlt, 0, 0, 0));
	endtask

	// ISA-level model, one instruction per step
	task automatic run_model();
		word_t regs [4];
		word_t pc;
		word_t npc;
		word_t ins;
		word_t sx;
		word_t addr;
		word_t port;
		word_t target;
		logic [3:0] op;
		logic [5:0] fn;
		int rs;
		int rt;
		int rd;
		int i;
		logic done;
		for (i = 0; i < mem_words; i++) begin
			model_mem[i] = image[i];
		end
		for (i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		port = '0;
		done = 1'b0;
		exp_count = 0;
		exp_port.delete();
		exp_port.push_back(port);
		exp_wr_addr.delete();
		exp_wr_data.delete();
		while (!done && exp_count < max_steps) begin
			ins = model_mem[pc];
			op = ins[15:12];
			rs = ins[11:10];
			rt = ins[9:8];
			rd = ins[7:6];
			fn = ins[5:0];
			sx = {{8{ins[7]}}, ins[7:0]};
			npc = pc + 1'b1;
			target = {npc[15:12], ins[11:0]};
			case (op)
				tsc_pkg::op_bne: if (regs[rs] != regs[rt]) npc = npc + sx;
				tsc_pkg::op_beq: if (regs[rs] == regs[rt]) npc = npc + sx;
				tsc_pkg::op_bgz: if ($signed(regs[rs]) > 0) npc = npc + sx;
				tsc_pkg::op_blz: if ($signed(regs[rs]) < 0) npc = npc + sx;
				tsc_pkg::op_adi: regs[rt] = regs[rs] + sx;
				tsc_pkg::op_ori: regs[rt] = regs[rs] | {8'h00, ins[7:0]};
				tsc_pkg::op_lhi: regs[rt] = {ins[7:0], 8'h00};
				tsc_pkg::op_lwd: regs[rt] = model_mem[word_t'(regs[rs] + sx)];
				tsc_pkg::op_swd: begin
					addr = regs[rs] + sx;
					model_mem[addr] = regs[rt];
					exp_wr_addr.push_back(addr);
					exp_wr_data.push_back(regs[rt]);
				end
				tsc_pkg::op_jmp: npc = target;
				tsc_pkg::op_jal: begin
					regs[2] = npc;
					npc = target;
				end
				tsc_pkg::op_rtype: begin
					case (fn)
						tsc_pkg::fn_add: regs[rd] = regs[rs] + regs[rt];
						tsc_pkg::fn_sub: regs[rd] = regs[rs] - regs[rt];
						tsc_pkg::fn_and: regs[rd] = regs[rs] & regs[rt];
						tsc_pkg::fn_orr: regs[rd] = regs[rs] | regs[rt];
						tsc_pkg::fn_not: regs[rd] = ~regs[rs];
						tsc_pkg::fn_tcp: regs[rd] = -regs[rs];
						tsc_pkg::fn_shl: regs[rd] = regs[rs] << 1;
						tsc_pkg::fn_shr: regs[rd] = $signed(regs[rs]) >>> 1;
						tsc_pkg::fn_jpr: npc = regs[rs];
						tsc_pkg::fn_jrl: begin
							addr = regs[rs];
							regs[2] = npc;
							npc = addr;
						end
						tsc_pkg::fn_wwd: port = regs[rs];
						tsc_pkg::fn_hlt: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = npc;
			exp_count++;
			exp_port.push_back(port);
		end
		if (!done) begin
			note_failure("reference model did not reach HLT");
		end
	endtask

	task automatic run_program(input string name);
		int errors_before;
		int i;
		errors_before = errors;
		checking = 1'b0;
		run_model();
		@(posedge clk);
		#2;
		reset_n = 1'b0;
		for (i = 0; i < mem_words; i++) begin
			mem_model.load_word(word_t'(i), image[i]);
		end
		mem_model.clear_log();
		repeat (10) @(posedge clk);
		#2;
		reset_n = 1'b1;
		checking = 1'b1;
		while (!is_halted) @(negedge clk);
		// A few idle cycles so the halt checks see the HALT state
		repeat (8) @(negedge clk);
		compare_word("num_inst", num_inst, word_t'(exp_count));
		compare_word("write count", word_t'(mem_model.log_addr.size()),
			word_t'(exp_wr_addr.size()));
		for (i = 0; i < exp_wr_addr.size() && i < mem_model.log_addr.size(); i++) begin
			compare_word("write address", mem_model.log_addr[i], exp_wr_addr[i]);
			compare_word("write data", mem_model.log_data[i], exp_wr_data[i]);
		end
		if (errors == errors_before) begin
			$display("test %s: passed, %0d instructions", name, exp_count);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic build_alu_test();
		int k;
		int rs;
		int rt;
		int rd;
		logic [3:0] op;
		start_program();
		for (k = 0; k < 4; k++) begin
			load_const(k, word_t'($urandom));
		end
		// Function codes 0 to 7 are the R-type ALU operations
		for (k = 0; k < 8; k++) begin
			rs = $urandom % 4;
			rt = $urandom % 4;
			rd = $urandom % 4;
			emit(r_instr(k, rs, rt, rd));
			emit_wwd(rd);
		end
		for (k = 0; k < 6; k++) begin
			rs = $urandom % 4;
			rt = $urandom % 4;
			case (k % 3)
				0: op = tsc_pkg::op_adi;
				1: op = tsc_pkg::op_ori;
				default: op = tsc_pkg::op_lhi;
			endcase
			emit(i_instr(op, rs, rt, $urandom % 256));
			emit_wwd(rt);
		end
		emit_halt();
	endtask

	task automatic build_memory_test();
		int k;
		int off;
		int first_off;
		start_program();
		// Data area well above the program
		load_const(0, word_t'(16'h1000 + ($urandom % 32'h5000)));
		first_off = 0;
		for (k = 0; k < 4; k++) begin
			off = $urandom % 256;
			if (k == 0) begin
				first_off = off;
			end
			load_const(1, word_t'($urandom));
			emit(i_instr(tsc_pkg::op_swd, 0, 1, off));
			emit(i_instr(tsc_pkg::op_lwd, 0, 2 + k % 2, off));
			emit_wwd(2 + k % 2);
		end
		emit(i_instr(tsc_pkg::op_lwd, 0, 3, first_off));
		emit_wwd(3);
		emit_halt();
	endtask

	task automatic build_branch_test();
		int k;
		logic taken;
		logic [3:0] op;
		logic [7:0] mark;
		word_t a;
		word_t b;
		start_program();
		for (k = 0; k < 8; k++) begin
			op = k / 2;
			taken = k % 2;
			a = word_t'($urandom);
			b = word_t'($urandom);
			case (op)
				tsc_pkg::op_bne: b = taken ? a ^ word_t'($urandom % 32'hffff + 1) : a;
				tsc_pkg::op_beq: b = taken ? a : a ^ word_t'($urandom % 32'hffff + 1);
				tsc_pkg::op_bgz: a = taken ? {1'b0, a[14:1], 1'b1} : {1'b1, a[14:0]};
				default: a = taken ? {1'b1, a[14:0]} : {1'b0, a[14:0]};
			endcase
			mark = $urandom % 256;
			load_const(0, a);
			load_const(1, b);
			// Taken skips the first marker pair
			emit(i_instr(op, 0, 1, 2));
			emit(i_instr(tsc_pkg::op_lhi, 0, 3, mark));
			emit_wwd(3);
			emit(i_instr(tsc_pkg::op_lhi, 0, 3, mark ^ 8'h80));
			emit_wwd(3);
		end
		// Countdown loop with a backward branch
		load_const(0, 16'd3);
		load_const(1, 16'd0);
		emit(i_instr(tsc_pkg::op_adi, 0, 0, -1));
		emit_wwd(0);
		emit(i_instr(tsc_pkg::op_bne, 0, 1, -3));
		emit_halt();
	endtask

	task automatic build_jump_test();
		int sub1;
		int sub2;
		start_program();
		sub1 = 16'h20 + $urandom % 16;
		sub2 = 16'h40 + $urandom % 32;
		load_const(1, word_t'(sub2));
		emit(j_instr(tsc_pkg::op_jal, sub1));
		emit_wwd(2);
		emit(r_instr(tsc_pkg::fn_jrl, 1, 0, 0));
		emit_wwd(2);
		emit(j_instr(tsc_pkg::op_jmp, cursor + 3));
		emit(i_instr(tsc_pkg::op_lhi, 0, 3, 8'hee));
		emit_wwd(3);
		emit_halt();
		cursor = sub1;
		emit_wwd(2);
		emit(i_instr(tsc_pkg::op_lhi, 0, 3, $urandom % 256));
		emit_wwd(3);
		emit(r_instr(tsc_pkg::fn_jpr, 2, 0, 0));
		cursor = sub2;
		emit_wwd(2);
		emit(r_instr(tsc_pkg::fn_jpr, 2, 0, 0));
	endtask

	initial begin
		seed_draw = $urandom(32'h4218);
		build_alu_test();
		run_program("alu");
		build_memory_test();
		run_program("memory");
		build_branch_test();
		run_program("branch");
		build_jump_test();
		run_program("jump");
		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			num_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Longest test at 7 cycles per instruction
	initial begin
		#(num_tests * max_steps * 7 * clk_period);
		$display("timeout: the run did not finish in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== tsc_cpu.f ====
common/tsc_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/datapath.sv
hw/control_fsm.sv
hw/cpu.sv
tests/tb_memory.sv
tests/tb_cpu.sv
